// ==== all.f ====
common/bus_pkg.sv
common/video_pkg.sv
common/mem_read_if.sv
timing/display_timing.sv
source/display_regs.sv
source/dma_fetch.sv
source/pixel_fifo.sv
source/vga_top.sv
verif/mem_model.sv
verif/tb_vga_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the VGA testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vga_top -f all.f -o tb_vga_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_vga_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== verif/tb_vga_top.sv ====
`timescale 1ns/1ns

module tb_vga_top;

    localparam logic [31:0] PIX_KEY = 32'h005A_C3E1;
    localparam logic [31:0] FB_BASE = 32'h0000_1000;
    localparam logic [31:0] FB_LENGTH = 32'd128;
    localparam int LINE_PX = 24;
    localparam int FRAME_PX = 24 * 12;
    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        reset;
    logic        io_write_en;
    logic        io_read_en;
    logic [31:0] io_address;
    logic [31:0] io_write_data;
    logic [31:0] io_read_data;
    logic        frame_interrupt;
    logic        mem_ar_valid;
    logic        mem_ar_ready;
    logic [31:0] mem_ar_addr;
    logic [7:0]  mem_ar_len;
    logic        mem_r_valid;
    logic [31:0] mem_r_data;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_blank_n;
    logic        vga_hs;
    logic        vga_vs;

    // Error count per test
    // Test 1 sits at index 0
    int errs[6];
    int hung;

    // Checker state
    logic        hs_q;
    logic        vs_q;
    logic        hs_seen;
    logic        vs_seen;
    logic        irq_seen;
    int          hs_period;
    int          hs_low;
    int          vs_low;
    int          irq_period;
    logic        pix_on;
    logic        pend;
    logic [23:0] pend_val;
    int          pix_k;
    logic        burst_on;
    int          req_n;
    logic        dis_on;
    logic        ar_valid_q;
    int          dis_beats;
    int          dis_rises;

    vga_top #(
        .BASE_ADDRESS(32'h0),
        .BURST_LEN(16),
        .FIFO_DEPTH(32),
        .H_VISIBLE_PX(16),
        .H_FRONT_PX(2),
        .H_SYNC_PX(3),
        .H_BACK_PX(3),
        .V_VISIBLE_LN(8),
        .V_FRONT_LN(1),
        .V_SYNC_LN(2),
        .V_BACK_LN(1)
    ) u_vga_top (
        .clk(clk),
        .reset(reset),
        .io_write_en(io_write_en),
        .io_read_en(io_read_en),
        .io_address(io_address),
        .io_write_data(io_write_data),
        .io_read_data(io_read_data),
        .frame_interrupt(frame_interrupt),
        .mem_ar_valid(mem_ar_valid),
        .mem_ar_ready(mem_ar_ready),
        .mem_ar_addr(mem_ar_addr),
        .mem_ar_len(mem_ar_len),
        .mem_r_valid(mem_r_valid),
        .mem_r_data(mem_r_data),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b),
        .vga_clk(vga_clk),
        .vga_blank_n(vga_blank_n),
        .vga_hs(vga_hs),
        .vga_vs(vga_vs)
    );

    mem_model #(
        .DATA_KEY(PIX_KEY),
        .SEED(32'd56698)
    ) u_mem_model (
        .clk(clk),
        .reset(reset),
        .ar_valid(mem_ar_valid),
        .ar_addr(mem_ar_addr),
        .ar_len(mem_ar_len),
        .ar_ready(mem_ar_ready),
        .r_valid(mem_r_valid),
        .r_data(mem_r_data)
    );

    initial
        clk = 1'b0;

    always
        #50 clk = !clk;

    function automatic string test_name(int idx);
        case (idx)
            0: return "reset_state";
            1: return "register_readback";
            2: return "sync_timing";
            3: return "burst_addressing";
            4: return "pixel_stream";
            default: return "disable";
        endcase
    endfunction

    // RGB that memory holds for one byte address
    function automatic logic [23:0] pixel_at(logic [31:0] addr);
        logic [31:0] word;
        word = (addr ^ PIX_KEY) << 8;
        return word[31:8];
    endfunction

    task automatic compare(int idx, logic [31:0] expected, logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            errs[idx]++;
            $display("[ERROR] %s expected %h actual %h", test_name(idx), expected, actual);
        end
    endtask

    task automatic report_test(int idx);
        if (errs[idx] == 0)
            $display("Test %0d %s: pass", idx + 1, test_name(idx));
        else
            $display("Test %0d %s: fail, %0d errors", idx + 1, test_name(idx), errs[idx]);
    endtask

    task automatic write_reg(logic [31:0] addr, logic [31:0] data);
        io_write_en = 1'b1;
        io_address = addr;
        io_write_data = data;
        @(posedge clk);
        #1;
        io_write_en = 1'b0;
    endtask

    // Readback is combinational and sampled at the next edge
    task automatic read_reg(logic [31:0] addr, output logic [31:0] data);
        io_read_en = 1'b1;
        io_address = addr;
        @(posedge clk);
        data = io_read_data;
        #1;
        io_read_en = 1'b0;
    endtask

    // Counts frame interrupts
    // Each one has WAIT_LIMIT clks to arrive
    task automatic wait_frames(int n);
        int waited;
        for (int i = 0; i < n; i++)
        begin
            waited = 0;
            do
            begin
                @(posedge clk);
                waited++;
            end
            while (!frame_interrupt && waited < WAIT_LIMIT);
            if (!frame_interrupt)
            begin
                $display("Timed out waiting for a frame interrupt");
                hung = 1;
                return;
            end
            #1;
        end
    endtask

    task automatic wait_handshake();
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!(mem_ar_valid && mem_ar_ready) && waited < WAIT_LIMIT);
        if (!(mem_ar_valid && mem_ar_ready))
        begin
            $display("Timed out waiting for a burst request to be accepted");
            hung = 1;
        end
        #1;
    endtask

    // Burst length is fixed on every request
    assert property (@(posedge clk) disable iff (reset) mem_ar_valid |-> mem_ar_len == 8'd15)
    else
    begin
        errs[3]++;
        $display("[ERROR] %s expected %h actual %h", test_name(3), 8'd15, mem_ar_len);
    end

    // A request only starts with room for a whole burst
    assert property (@(posedge clk) disable iff (reset)
        $rose(mem_ar_valid) |-> u_vga_top.fifo_almost_empty)
    else
    begin
        errs[3]++;
        $display("Burst request issued while the FIFO had no room for a burst");
    end

    // Sync widths and periods in pixel enables
    always @(posedge clk)
    begin
        if (reset)
        begin
            hs_q = 1'b1;
            vs_q = 1'b1;
            hs_seen = 1'b0;
            vs_seen = 1'b0;
            irq_seen = 1'b0;
        end
        else
        begin
            if (hs_q && !vga_hs)
            begin
                if (hs_seen)
                    compare(2, LINE_PX, hs_period);
                hs_seen = 1'b1;
                hs_period = 0;
                hs_low = 0;
            end
            else if (!hs_q && vga_hs)
                compare(2, 3, hs_low);
            if (vs_q && !vga_vs)
            begin
                vs_seen = 1'b1;
                vs_low = 0;
            end
            else if (!vs_q && vga_vs && vs_seen)
                compare(2, 2 * LINE_PX, vs_low);
            if (frame_interrupt)
            begin
                if (irq_seen)
                    compare(2, FRAME_PX, irq_period);
                // First pixel of the first blanked line
                compare(2, 0, {31'd0, vga_blank_n});
                compare(2, 1, {31'd0, vga_hs});
                irq_seen = 1'b1;
                irq_period = 0;
            end
            if (vga_clk)
            begin
                hs_period++;
                irq_period++;
                if (!vga_hs)
                    hs_low++;
                if (!vga_vs)
                    vs_low++;
            end
            hs_q = vga_hs;
            vs_q = vga_vs;
        end
    end

    // Pixel values one clk after each visible dequeue
    always @(posedge clk)
    begin
        if (reset)
            pend = 1'b0;
        else
        begin
            if (pend)
                compare(4, {8'd0, pend_val}, {8'd0, vga_r, vga_g, vga_b});
            pend = 1'b0;
            if (pix_on && vga_clk && vga_blank_n)
            begin
                assert (!u_vga_top.fifo_empty)
                else
                begin
                    errs[4]++;
                    $display("FIFO ran empty at visible pixel %0d", pix_k);
                end
                pend = 1'b1;
                pend_val = pixel_at(FB_BASE + 32'(pix_k * 4));
                pix_k++;
            end
        end
    end

    // Request addresses and count per frame
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (frame_interrupt)
            begin
                if (burst_on)
                    compare(3, 8, req_n);
                req_n = 0;
            end
            if (mem_ar_valid && mem_ar_ready)
            begin
                if (burst_on)
                    compare(3, FB_BASE + 32'(64 * req_n), mem_ar_addr);
                req_n++;
            end
        end
    end

    // Traffic after enable is cleared
    always @(posedge clk)
    begin
        if (reset)
            ar_valid_q = 1'b0;
        else
        begin
            if (dis_on)
            begin
                if (mem_r_valid)
                    dis_beats++;
                if (mem_ar_valid && !ar_valid_q)
                    dis_rises++;
            end
            ar_valid_q = mem_ar_valid;
        end
    end

    task automatic run_tests();
        logic [31:0] data;

        // Test 1 checks idle outputs once reset is released
        repeat (2) @(posedge clk);
        compare(0, 0, {31'd0, mem_ar_valid});
        compare(0, 0, {31'd0, frame_interrupt});
        compare(0, 0, {31'd0, vga_blank_n});
        compare(0, 1, {31'd0, vga_hs});
        compare(0, 1, {31'd0, vga_vs});
        #1;
        report_test(0);

        // Test 2 writes base and length first so the first fetch is sane
        write_reg(32'd4, FB_BASE);
        read_reg(32'd4, data);
        compare(1, FB_BASE, data);
        write_reg(32'd8, FB_LENGTH);
        read_reg(32'd8, data);
        compare(1, FB_LENGTH, data);
        write_reg(32'd0, 32'd1);
        read_reg(32'd0, data);
        compare(1, 32'd1, data);
        report_test(1);

        // Tests 3 to 5 over the frame fetched after the second interrupt
        wait_frames(2);
        if (hung != 0)
            return;
        pix_on = 1'b1;
        pix_k = 0;
        burst_on = 1'b1;
        wait_frames(1);
        if (hung != 0)
            return;
        pix_on = 1'b0;
        burst_on = 1'b0;
        compare(4, 128, pix_k);
        report_test(2);
        report_test(3);
        report_test(4);

        // Test 6 drops enable while a burst is under way
        wait_handshake();
        if (hung != 0)
            return;
        dis_on = 1'b1;
        write_reg(32'd0, 32'd0);
        wait_frames(2);
        if (hung != 0)
            return;
        dis_on = 1'b0;
        compare(5, 0, dis_rises);
        assert (dis_beats <= 16)
        else
        begin
            errs[5]++;
            $display("[ERROR] %s expected %0d actual %0d", test_name(5), 16, dis_beats);
        end
        report_test(5);
    endtask

    initial
    begin
        int failed;
        reset = 1'b1;
        io_write_en = 1'b0;
        io_read_en = 1'b0;
        io_address = '0;
        io_write_data = '0;
        hung = 0;
        pix_on = 1'b0;
        pix_k = 0;
        burst_on = 1'b0;
        req_n = 0;
        dis_on = 1'b0;
        dis_beats = 0;
        dis_rises = 0;
        foreach (errs[i])
            errs[i] = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        run_tests();

        failed = 0;
        foreach (errs[i])
            if (errs[i] != 0)
                failed++;
        $display("Tests run: 6, passed: %0d, failed: %0d", 6 - failed, failed);
        if (hung == 0 && failed == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/1ns

// Burst read memory for the testbench
// Each beat returns its own address XOR a key, shifted into bits 31:8
module mem_model
    #(
        parameter logic [31:0] DATA_KEY = 32'h0000_0000,
        parameter logic [31:0] SEED = 32'd56698
    )
    (
        input  logic        clk,
        input  logic        reset,
        input  logic        ar_valid,
        input  logic [31:0] ar_addr,
        input  logic [7:0]  ar_len,
        output logic        ar_ready,
        output logic        r_valid,
        output logic [31:0] r_data
    );

    logic [31:0] lcg_state;
    logic [31:0] burst_addr;
    int          burst_beats;
    int          delay;

    // Linear congruential generator, upper bits are the better ones
    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    initial
    begin
        lcg_state = SEED;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_data = '0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!reset && ar_valid)
            begin
                // Accept the request after 0 to 3 clks
                delay = next_rand() % 4;
                repeat (delay)
                begin
                    @(posedge clk);
                    #1;
                end
                ar_ready = 1'b1;
                burst_addr = ar_addr;
                burst_beats = int'(ar_len) + 1;
                @(posedge clk);
                #1;
                ar_ready = 1'b0;
                for (int beat = 0; beat < burst_beats; beat++)
                begin
                    // Gap of 0 to 2 clks ahead of each beat
                    delay = next_rand() % 3;
                    repeat (delay)
                    begin
                        @(posedge clk);
                        #1;
                    end
                    r_valid = 1'b1;
                    r_data = ((burst_addr + 32'(beat * 4)) ^ DATA_KEY) << 8;
                    @(posedge clk);
                    #1;
                    r_valid = 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/vga_top.sv ====
`timescale 1ns/1ns

module vga_top
    import bus_pkg::*, video_pkg::*;
    #(
        parameter logic [ADDR_WIDTH-1:0] BASE_ADDRESS = '0,
        parameter int BURST_LEN = BURST_LEN_DEFAULT,
        parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT,
        parameter int H_VISIBLE_PX = H_VISIBLE,
        parameter int H_FRONT_PX = H_FRONT,
        parameter int H_SYNC_PX = H_SYNC,
        parameter int H_BACK_PX = H_BACK,
        parameter int V_VISIBLE_LN = V_VISIBLE,
        parameter int V_FRONT_LN = V_FRONT,
        parameter int V_SYNC_LN = V_SYNC,
        parameter int V_BACK_LN = V_BACK
    )
    (
        input  logic                  clk,
        input  logic                  reset,

        // I/O bus
        input  logic                  io_write_en,
        input  logic                  io_read_en,
        input  logic [ADDR_WIDTH-1:0] io_address,
        input  logic [DATA_WIDTH-1:0] io_write_data,
        output logic [DATA_WIDTH-1:0] io_read_data,
        output logic                  frame_interrupt,

        // Burst read port to memory
        output logic                  mem_ar_valid,
        input  logic                  mem_ar_ready,
        output logic [ADDR_WIDTH-1:0] mem_ar_addr,
        output logic [7:0]            mem_ar_len,
        input  logic                  mem_r_valid,
        input  logic [DATA_WIDTH-1:0] mem_r_data,

        // DAC pins
        output logic [7:0]            vga_r,
        output logic [7:0]            vga_g,
        output logic [7:0]            vga_b,
        output logic                  vga_clk,
        output logic                  vga_blank_n,
        output logic                  vga_hs,
        output logic                  vga_vs
    );

    logic                  pixel_en;
    logic                  visible;
    logic                  start_frame;
    logic                  enable;
    logic [ADDR_WIDTH-1:0] fb_base;
    logic [DATA_WIDTH-1:0] fb_length;
    logic                  fifo_empty;
    logic                  fifo_almost_empty;
    pixel_t                fifo_in;
    pixel_t                pixel_out;

    mem_read_if mem();

    // Memory channel out to the pins
    assign mem_ar_valid = mem.ar_valid;
    assign mem_ar_addr = mem.ar_addr;
    assign mem_ar_len = mem.ar_len;
    assign mem.ar_ready = mem_ar_ready;
    assign mem.r_valid = mem_r_valid;
    assign mem.r_data = mem_r_data;

    // Alpha byte dropped
    assign fifo_in = pixel_t'(mem.r_data[31:8]);

    assign frame_interrupt = start_frame;
    assign vga_clk = pixel_en;
    assign vga_blank_n = visible;
    assign vga_r = pixel_out.red;
    assign vga_g = pixel_out.green;
    assign vga_b = pixel_out.blue;

    display_timing #(
        .H_VISIBLE_PX(H_VISIBLE_PX),
        .H_FRONT_PX(H_FRONT_PX),
        .H_SYNC_PX(H_SYNC_PX),
        .H_BACK_PX(H_BACK_PX),
        .V_VISIBLE_LN(V_VISIBLE_LN),
        .V_FRONT_LN(V_FRONT_LN),
        .V_SYNC_LN(V_SYNC_LN),
        .V_BACK_LN(V_BACK_LN)
    ) u_display_timing (
        .clk(clk),
        .reset(reset),
        .pixel_en(pixel_en),
        .visible(visible),
        .start_frame(start_frame),
        .hs(vga_hs),
        .vs(vga_vs)
    );

    display_regs #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) u_display_regs (
        .clk(clk),
        .reset(reset),
        .write_en(io_write_en),
        .read_en(io_read_en),
        .address(io_address),
        .write_data(io_write_data),
        .read_data(io_read_data),
        .enable(enable),
        .fb_base(fb_base),
        .fb_length(fb_length)
    );

    dma_fetch #(
        .BURST_LEN(BURST_LEN)
    ) u_dma_fetch (
        .clk(clk),
        .reset(reset),
        .start_frame(start_frame),
        .enable(enable),
        .fifo_room(fifo_almost_empty),
        .fb_base(fb_base),
        .fb_length(fb_length),
        .mem(mem.master)
    );

    // Flushed at each frame start so an underrun cannot carry over
    pixel_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .BURST_LEN(BURST_LEN)
    ) u_pixel_fifo (
        .clk(clk),
        .reset(reset),
        .flush(start_frame),
        .enqueue(mem.r_valid),
        .value_in(fifo_in),
        .dequeue(pixel_en && visible && !fifo_empty),
        .value_out(pixel_out),
        .empty(fifo_empty),
        .almost_empty(fifo_almost_empty)
    );

endmodule

// ==== source/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo
    import video_pkg::*;
    #(
        parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT,
        parameter int BURST_LEN = 16
    )
    (
        input  logic   clk,
        input  logic   reset,
        input  logic   flush,
        input  logic   enqueue,
        input  pixel_t value_in,
        input  logic   dequeue,
        output pixel_t value_out,
        output logic   empty,
        output logic   almost_empty
    );

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pixel_t           storage[FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    assign empty = (count == '0);

    // Room for one more whole burst
    assign almost_empty = int'(count) <= FIFO_DEPTH - BURST_LEN;

    // Pointers and occupancy
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enqueue)
                wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (dequeue)
                rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (enqueue && !dequeue)
                count <= count + 1'b1;
            else if (dequeue && !enqueue)
                count <= count - 1'b1;
        end
    end

    // Storage and the output register
    // Head word moves out on the dequeue edge
    always_ff @(posedge clk)
    begin
        if (enqueue)
            storage[wr_ptr] <= value_in;
        if (dequeue)
            value_out <= storage[rd_ptr];
    end

endmodule

// ==== source/dma_fetch.sv ====
`timescale 1ns/1ns

module dma_fetch
    import bus_pkg::*;
    #(
        parameter int BURST_LEN = BURST_LEN_DEFAULT
    )
    (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  start_frame,
        input  logic                  enable,
        input  logic                  fifo_room,
        input  logic [ADDR_WIDTH-1:0] fb_base,
        input  logic [DATA_WIDTH-1:0] fb_length,
        mem_read_if.master            mem
    );

    typedef enum logic [1:0] {
        STATE_WAIT_FRAME,
        STATE_WAIT_SPACE,
        STATE_ISSUE_ADDR,
        STATE_BURST_ACTIVE
    } dma_state_t;

    dma_state_t            state;
    logic [7:0]            beat_count;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic [DATA_WIDTH-1:0] pixel_count;
    logic [DATA_WIDTH-1:0] next_pixel_count;
    logic                  last_beat;

    // Pixels fetched once the current burst lands
    assign next_pixel_count = pixel_count + DATA_WIDTH'(BURST_LEN);
    assign last_beat = mem.r_valid && (int'(beat_count) == BURST_LEN - 1);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= STATE_WAIT_FRAME;
            beat_count <= '0;
            fetch_addr <= '0;
            pixel_count <= '0;
        end
        else
        begin
            unique case (state)
                // Idle until the next vertical blank starts a fetch
                // Also recovers after an underrun since the FIFO flushes here
                STATE_WAIT_FRAME:
                begin
                    if (start_frame && enable)
                    begin
                        state <= STATE_ISSUE_ADDR;
                        fetch_addr <= fb_base;
                        pixel_count <= '0;
                    end
                end

                // Hold off until a whole burst fits in the FIFO
                STATE_WAIT_SPACE:
                begin
                    if (fifo_room)
                        state <= STATE_ISSUE_ADDR;
                end

                // Request stays on the bus until accepted
                STATE_ISSUE_ADDR:
                begin
                    if (mem.ar_ready)
                        state <= STATE_BURST_ACTIVE;
                end

                // Room is judged again once the last beat sits in the FIFO
                STATE_BURST_ACTIVE:
                begin
                    if (last_beat)
                    begin
                        beat_count <= '0;
                        fetch_addr <= fetch_addr + ADDR_WIDTH'(BURST_LEN * 4);
                        pixel_count <= next_pixel_count;
                        if (next_pixel_count >= fb_length || !enable)
                            state <= STATE_WAIT_FRAME;
                        else
                            state <= STATE_WAIT_SPACE;
                    end
                    else if (mem.r_valid)
                        beat_count <= beat_count + 8'd1;
                end

                default:
                    state <= STATE_WAIT_FRAME;
            endcase
        end
    end

    assign mem.ar_valid = (state == STATE_ISSUE_ADDR);
    assign mem.ar_addr = fetch_addr;
    assign mem.ar_len = 8'(BURST_LEN - 1);

endmodule

// ==== source/display_regs.sv ====
`timescale 1ns/1ns

module display_regs
    import bus_pkg::*;
    #(
        parameter logic [ADDR_WIDTH-1:0] BASE_ADDRESS = '0
    )
    (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  write_en,
        input  logic                  read_en,
        input  logic [ADDR_WIDTH-1:0] address,
        input  logic [DATA_WIDTH-1:0] write_data,
        output logic [DATA_WIDTH-1:0] read_data,
        output logic                  enable,
        output logic [ADDR_WIDTH-1:0] fb_base,
        output logic [DATA_WIDTH-1:0] fb_length
    );

    // Absolute register addresses
    localparam logic [ADDR_WIDTH-1:0] ENABLE_ADDR = BASE_ADDRESS + ADDR_WIDTH'(REG_ENABLE);
    localparam logic [ADDR_WIDTH-1:0] BASE_ADDR = BASE_ADDRESS + ADDR_WIDTH'(REG_FB_BASE);
    localparam logic [ADDR_WIDTH-1:0] LENGTH_ADDR = BASE_ADDRESS + ADDR_WIDTH'(REG_FB_LENGTH);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            enable <= 1'b0;
            fb_base <= '0;
            fb_length <= '0;
        end
        else if (write_en)
        begin
            case (address)
                ENABLE_ADDR: enable <= write_data[0];
                BASE_ADDR: fb_base <= write_data;
                LENGTH_ADDR: fb_length <= write_data;
                default: ;
            endcase
        end
    end

    // Readback, zero when idle or unmapped
    always_comb
    begin
        read_data = '0;
        if (read_en)
        begin
            case (address)
                ENABLE_ADDR: read_data = DATA_WIDTH'(enable);
                BASE_ADDR: read_data = fb_base;
                LENGTH_ADDR: read_data = fb_length;
                default: read_data = '0;
            endcase
        end
    end

endmodule

// ==== timing/display_timing.sv ====
`timescale 1ns/1ns

module display_timing
    import video_pkg::*;
    #(
        parameter int H_VISIBLE_PX = H_VISIBLE,
        parameter int H_FRONT_PX = H_FRONT,
        parameter int H_SYNC_PX = H_SYNC,
        parameter int H_BACK_PX = H_BACK,
        parameter int V_VISIBLE_LN = V_VISIBLE,
        parameter int V_FRONT_LN = V_FRONT,
        parameter int V_SYNC_LN = V_SYNC,
        parameter int V_BACK_LN = V_BACK
    )
    (
        input  logic clk,
        input  logic reset,
        output logic pixel_en,
        output logic visible,
        output logic start_frame,
        output logic hs,
        output logic vs
    );

    // Line and frame lengths
    localparam int H_TOTAL = H_VISIBLE_PX + H_FRONT_PX + H_SYNC_PX + H_BACK_PX;
    localparam int V_TOTAL = V_VISIBLE_LN + V_FRONT_LN + V_SYNC_LN + V_BACK_LN;

    // Sync windows include the start and exclude the end
    localparam int H_SYNC_START = H_VISIBLE_PX + H_FRONT_PX;
    localparam int H_SYNC_END = H_SYNC_START + H_SYNC_PX;
    localparam int V_SYNC_START = V_VISIBLE_LN + V_FRONT_LN;
    localparam int V_SYNC_END = V_SYNC_START + V_SYNC_LN;

    localparam int H_CW = $clog2(H_TOTAL);
    localparam int V_CW = $clog2(V_TOTAL);

    logic [H_CW-1:0] h_count;
    logic [V_CW-1:0] v_count;

    // Pixel clock enable at half of clk
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            pixel_en <= 1'b0;
        else
            pixel_en <= !pixel_en;
    end

    // Column counter with the line counter stepping on each wrap
    // Out of reset the count sits on the last blanked line
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= V_CW'(V_TOTAL - 1);
        end
        else if (pixel_en)
        begin
            if (int'(h_count) == H_TOTAL - 1)
            begin
                h_count <= '0;
                if (int'(v_count) == V_TOTAL - 1)
                    v_count <= '0;
                else
                    v_count <= v_count + 1'b1;
            end
            else
                h_count <= h_count + 1'b1;
        end
    end

    assign visible = (int'(h_count) < H_VISIBLE_PX) && (int'(v_count) < V_VISIBLE_LN);

    // Both syncs active low
    assign hs = !((int'(h_count) >= H_SYNC_START) && (int'(h_count) < H_SYNC_END));
    assign vs = !((int'(v_count) >= V_SYNC_START) && (int'(v_count) < V_SYNC_END));

    // First pixel of the first blanked line
    assign start_frame = pixel_en && (h_count == '0) && (int'(v_count) == V_VISIBLE_LN);

endmodule

// ==== common/mem_read_if.sv ====
`timescale 1ns/1ns

// Read-only burst channel to memory
interface mem_read_if
    import bus_pkg::*;
    ();

    // Address channel, held by the master until ar_ready
    logic                  ar_valid;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic [7:0]            ar_len;
    logic                  ar_ready;

    // Read data, ar_len + 1 beats per burst and never throttled
    logic                  r_valid;
    logic [DATA_WIDTH-1:0] r_data;

    modport master(
        output ar_valid, ar_addr, ar_len,
        input ar_ready, r_valid, r_data);

    modport slave(
        input ar_valid, ar_addr, ar_len,
        output ar_ready, r_valid, r_data);

endinterface

// ==== common/video_pkg.sv ====
package video_pkg;

    // Default horizontal timing, counted in pixels
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACK = 48;

    // Default vertical timing, counted in lines
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT = 10;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 33;

    // Pixel buffer entries between memory and the DAC
    localparam int FIFO_DEPTH_DEFAULT = 32;

    // One displayed pixel
    // Comes from memory word bits 31:8, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

endpackage

// ==== common/bus_pkg.sv ====
package bus_pkg;

    // I/O bus and memory bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Register byte offsets from the block base address
    localparam int REG_ENABLE = 0;
    localparam int REG_FB_BASE = 4;
    localparam int REG_FB_LENGTH = 8;

    // Beats per read burst
    // 16 words is one 64 byte request
    localparam int BURST_LEN_DEFAULT = 16;

endpackage
